//--- fu_macros.svh
`ifndef FU_MACROS_SVH
`define FU_MACROS_SVH

// data word width of the integer datapath
`define FU_XLEN 64

// destination tag width
// enough for a 64-entry physical register file
`define FU_TAG_W 6

// multiplier pipeline depth
// must divide FU_XLEN, each stage handles one slice of the multiplier operand
// 2, 4 and 8 are the intended settings
`define FU_MULT_STAGES 4

`endif

//--- fu_pkg.sv
package fu_pkg;

  // alu opcodes, alpha integer operate group
  typedef enum logic [3:0] {
    alu_addq   = 4'd0,
    alu_subq   = 4'd1,
    alu_and    = 4'd2,
    alu_bic    = 4'd3,
    alu_bis    = 4'd4,
    alu_ornot  = 4'd5,
    alu_xor    = 4'd6,
    alu_eqv    = 4'd7,
    alu_srl    = 4'd8,
    alu_sll    = 4'd9,
    alu_sra    = 4'd10,
    alu_cmpult = 4'd11,
    alu_cmpeq  = 4'd12,
    alu_cmpule = 4'd13,
    alu_cmplt  = 4'd14,
    alu_cmple  = 4'd15
  } alu_func_t;

  // source of alu operand b
  typedef enum logic {
    opb_is_regb = 1'b0,
    opb_is_imm  = 1'b1
  } opb_select_t;

  // branch condition
  // bits 1:0 pick the test, bit 2 inverts it
  typedef enum logic [2:0] {
    br_lbc = 3'b000,
    br_eq  = 3'b001,
    br_lt  = 3'b010,
    br_le  = 3'b011,
    br_lbs = 3'b100,
    br_ne  = 3'b101,
    br_ge  = 3'b110,
    br_gt  = 3'b111
  } br_func_t;

endpackage

//--- alu.sv
`timescale 1ns/1ns
`include "fu_macros.svh"

module alu (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue,
  input  fu_pkg::alu_func_t    func,
  input  fu_pkg::opb_select_t  opb_select,
  input  logic [`FU_XLEN-1:0]  opa,
  input  logic [`FU_XLEN-1:0]  regb,
  input  logic [7:0]           imm,
  input  logic [`FU_TAG_W-1:0] tag,
  input  logic                 stall,
  output logic                 ready,
  output logic                 done,
  output logic [`FU_XLEN-1:0]  result,
  output logic [`FU_TAG_W-1:0] done_tag
);
  import fu_pkg::*;

  logic [`FU_XLEN-1:0] opb;
  logic [`FU_XLEN-1:0] alu_out;
  logic [`FU_XLEN-1:0] sign_fill;
  logic [5:0]          shamt;
  logic [6:0]          fill_shift;
  logic                accept;

  // signed less-than from unsigned compares
  function automatic logic signed_lt(input logic [`FU_XLEN-1:0] a, input logic [`FU_XLEN-1:0] b);
    logic lt;
    // same sign, unsigned order is the signed order
    if (a[`FU_XLEN-1] == b[`FU_XLEN-1])
      lt = (a < b);
    else
      // signs differ, the negative one is smaller
      lt = a[`FU_XLEN-1];
    return lt;
  endfunction

  // operand b: register or zero-extended literal
  assign opb = (opb_select == opb_is_imm) ? {{(`FU_XLEN-8){1'b0}}, imm} : regb;

  assign shamt = opb[5:0];
  // sign bits shifted in from the top for sra
  // a zero shift gives a shift of 64, which clears the fill
  assign fill_shift = 7'(`FU_XLEN) - {1'b0, shamt};
  assign sign_fill  = {`FU_XLEN{opa[`FU_XLEN-1]}} << fill_shift;

  always_comb begin
    alu_out = '0;
    case (func)
      alu_addq:   alu_out = opa + opb;
      alu_subq:   alu_out = opa - opb;
      alu_and:    alu_out = opa & opb;
      alu_bic:    alu_out = opa & ~opb;
      alu_bis:    alu_out = opa | opb;
      alu_ornot:  alu_out = opa | ~opb;
      alu_xor:    alu_out = opa ^ opb;
      alu_eqv:    alu_out = opa ^ ~opb;
      alu_srl:    alu_out = opa >> shamt;
      alu_sll:    alu_out = opa << shamt;
      alu_sra:    alu_out = (opa >> shamt) | sign_fill;
      // compares give 0 or 1 in a full word
      alu_cmpult: alu_out = {{(`FU_XLEN-1){1'b0}}, (opa < opb)};
      alu_cmpeq:  alu_out = {{(`FU_XLEN-1){1'b0}}, (opa == opb)};
      alu_cmpule: alu_out = {{(`FU_XLEN-1){1'b0}}, (opa <= opb)};
      alu_cmplt:  alu_out = {{(`FU_XLEN-1){1'b0}}, signed_lt(opa, opb)};
      alu_cmple:  alu_out = {{(`FU_XLEN-1){1'b0}}, (signed_lt(opa, opb) || (opa == opb))};
      default:    alu_out = '0;
    endcase
  end

  // busy only while a result waits on a stalled writeback
  assign ready  = !(done && stall);
  assign accept = issue && ready;

  always_ff @(posedge clock) begin
    if (reset)
      done <= 1'b0;
    else if (accept)
      done <= 1'b1;
    else if (!stall)
      done <= 1'b0;
  end

  // payload, loaded only on accept
  always_ff @(posedge clock) begin
    if (accept) begin
      result   <= alu_out;
      done_tag <= tag;
    end
  end

  // a stalled result stays put until writeback takes it
  a_hold_under_stall: assert property (
    @(posedge clock) disable iff (reset)
    done && stall |=> done && $stable(result) && $stable(done_tag)
  );

endmodule

//--- mult_stage.sv
`timescale 1ns/1ns
`include "fu_macros.svh"

module mult_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 valid_in,
  input  logic                 hold_next,
  input  logic [`FU_XLEN-1:0]  product_in,
  input  logic [`FU_XLEN-1:0]  mplier_in,
  input  logic [`FU_XLEN-1:0]  mcand_in,
  input  logic [`FU_TAG_W-1:0] tag_in,
  output logic                 hold,
  output logic                 valid_out,
  output logic [`FU_XLEN-1:0]  product_out,
  output logic [`FU_XLEN-1:0]  mplier_out,
  output logic [`FU_XLEN-1:0]  mcand_out,
  output logic [`FU_TAG_W-1:0] tag_out
);

  // bits of the multiplier consumed per stage
  localparam int SLICE = `FU_XLEN / `FU_MULT_STAGES;

  logic [`FU_XLEN-1:0] partial_product;
  logic [`FU_XLEN-1:0] next_product;
  logic [`FU_XLEN-1:0] next_mplier;
  logic [`FU_XLEN-1:0] next_mcand;

  // low slice times the already shifted multiplicand
  assign partial_product = mplier_in[SLICE-1:0] * mcand_in;
  assign next_product    = product_in + partial_product;

  // line up the next slice for the following stage
  assign next_mplier = mplier_in >> SLICE;
  assign next_mcand  = mcand_in << SLICE;

  // full and the stage ahead cannot take our item
  // an empty stage never holds, so bubbles get squeezed out
  assign hold = valid_out && hold_next;

  always_ff @(posedge clock) begin
    if (reset)
      valid_out <= 1'b0;
    else if (!hold)
      valid_out <= valid_in;
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      product_out <= next_product;
      mplier_out  <= next_mplier;
      mcand_out   <= next_mcand;
      tag_out     <= tag_in;
    end
  end

endmodule

//--- mult.sv
`timescale 1ns/1ns
`include "fu_macros.svh"

module mult (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue,
  input  logic                 stall,
  input  logic [`FU_XLEN-1:0]  opa,
  input  logic [`FU_XLEN-1:0]  opb,
  input  logic [`FU_TAG_W-1:0] tag,
  output logic                 ready,
  output logic                 done,
  output logic [`FU_XLEN-1:0]  result,
  output logic [`FU_TAG_W-1:0] done_tag
);

  // index 0 is the issue side, index k+1 is the output of stage k
  logic                 valid_chain   [0:`FU_MULT_STAGES];
  logic [`FU_XLEN-1:0]  product_chain [0:`FU_MULT_STAGES];
  logic [`FU_XLEN-1:0]  mplier_chain  [0:`FU_MULT_STAGES];
  logic [`FU_XLEN-1:0]  mcand_chain   [0:`FU_MULT_STAGES];
  logic [`FU_TAG_W-1:0] tag_chain     [0:`FU_MULT_STAGES];
  // hold_chain[k] is the hold of stage k, the last entry is the writeback stall
  logic                 hold_chain    [0:`FU_MULT_STAGES];

  // opa is the multiplier, opb the multiplicand, product starts at zero
  assign valid_chain[0]   = issue;
  assign product_chain[0] = '0;
  assign mplier_chain[0]  = opa;
  assign mcand_chain[0]   = opb;
  assign tag_chain[0]     = tag;
  assign hold_chain[`FU_MULT_STAGES] = stall;

  genvar k;
  generate
    for (k = 0; k < `FU_MULT_STAGES; k++) begin : g_stage
      mult_stage stage (
        .clock       (clock),
        .reset       (reset),
        .valid_in    (valid_chain[k]),
        .hold_next   (hold_chain[k+1]),
        .product_in  (product_chain[k]),
        .mplier_in   (mplier_chain[k]),
        .mcand_in    (mcand_chain[k]),
        .tag_in      (tag_chain[k]),
        .hold        (hold_chain[k]),
        .valid_out   (valid_chain[k+1]),
        .product_out (product_chain[k+1]),
        .mplier_out  (mplier_chain[k+1]),
        .mcand_out   (mcand_chain[k+1]),
        .tag_out     (tag_chain[k+1])
      );
    end
  endgenerate

  // first stage stuck means no room for a new item
  assign ready    = !hold_chain[0];
  assign done     = valid_chain[`FU_MULT_STAGES];
  assign result   = product_chain[`FU_MULT_STAGES];
  assign done_tag = tag_chain[`FU_MULT_STAGES];

  // an issue against a full front stage must not disturb the item sitting there
  a_no_accept_when_busy: assert property (
    @(posedge clock) disable iff (reset)
    issue && !ready |=> valid_chain[1] && $stable(tag_chain[1]) && $stable(product_chain[1])
  );

endmodule

//--- brcond.sv
`timescale 1ns/1ns
`include "fu_macros.svh"

module brcond (
  input  logic                issue,
  input  fu_pkg::br_func_t    func,
  input  logic [`FU_XLEN-1:0] opa,
  output logic                taken
);

  logic cond;
  logic is_zero;
  logic is_neg;

  assign is_zero = (opa == '0);
  // sign bit alone decides a signed compare against zero
  assign is_neg  = opa[`FU_XLEN-1];

  // low two bits of func pick the base test
  always_comb begin
    case (func[1:0])
      2'b00:   cond = !opa[0];
      2'b01:   cond = is_zero;
      2'b10:   cond = is_neg;
      default: cond = is_neg || is_zero;
    endcase
  end

  // bit 2 turns lbc/eq/lt/le into lbs/ne/ge/gt
  // nothing is taken without an issue
  assign taken = issue && (func[2] ? !cond : cond);

endmodule

//--- fu_bank.sv
`timescale 1ns/1ns
`include "fu_macros.svh"

module fu_bank (
  input  logic                 clock,
  input  logic                 reset,
  // alu port
  input  logic                 alu_issue,
  input  fu_pkg::alu_func_t    alu_func,
  input  fu_pkg::opb_select_t  alu_opb_select,
  input  logic [`FU_XLEN-1:0]  alu_opa,
  input  logic [`FU_XLEN-1:0]  alu_regb,
  input  logic [7:0]           alu_imm,
  input  logic [`FU_TAG_W-1:0] alu_tag,
  input  logic                 alu_stall,
  output logic                 alu_ready,
  output logic                 alu_done,
  output logic [`FU_XLEN-1:0]  alu_result,
  output logic [`FU_TAG_W-1:0] alu_done_tag,
  // multiplier port
  input  logic                 mult_issue,
  input  logic [`FU_XLEN-1:0]  mult_opa,
  input  logic [`FU_XLEN-1:0]  mult_opb,
  input  logic [`FU_TAG_W-1:0] mult_tag,
  input  logic                 mult_stall,
  output logic                 mult_ready,
  output logic                 mult_done,
  output logic [`FU_XLEN-1:0]  mult_result,
  output logic [`FU_TAG_W-1:0] mult_done_tag,
  // branch condition port, no clock needed
  input  logic                 br_issue,
  input  fu_pkg::br_func_t     br_func,
  input  logic [`FU_XLEN-1:0]  br_opa,
  output logic                 br_taken
);

  // single cycle alu
  alu alu_unit (
    .clock      (clock),
    .reset      (reset),
    .issue      (alu_issue),
    .func       (alu_func),
    .opb_select (alu_opb_select),
    .opa        (alu_opa),
    .regb       (alu_regb),
    .imm        (alu_imm),
    .tag        (alu_tag),
    .stall      (alu_stall),
    .ready      (alu_ready),
    .done       (alu_done),
    .result     (alu_result),
    .done_tag   (alu_done_tag)
  );

  // pipelined multiplier, FU_MULT_STAGES deep
  mult mult_unit (
    .clock    (clock),
    .reset    (reset),
    .issue    (mult_issue),
    .stall    (mult_stall),
    .opa      (mult_opa),
    .opb      (mult_opb),
    .tag      (mult_tag),
    .ready    (mult_ready),
    .done     (mult_done),
    .result   (mult_result),
    .done_tag (mult_done_tag)
  );

  brcond br_unit (
    .issue (br_issue),
    .func  (br_func),
    .opa   (br_opa),
    .taken (br_taken)
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clock
);

  // 100 ns period, first rising edge at 50 ns
  initial begin
    clock = 1'b0;
  end

  always #50 clock = ~clock;

endmodule

//--- fu_bank_tb.sv
`timescale 1ns/1ns
`include "fu_macros.svh"

module fu_bank_tb;
  import fu_pkg::*;

  localparam int XLEN = `FU_XLEN;
  localparam int TAG_W = `FU_TAG_W;
  // cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic             clock;
  logic             reset;
  logic             alu_issue;
  alu_func_t        alu_func;
  opb_select_t      alu_opb_select;
  logic [XLEN-1:0]  alu_opa;
  logic [XLEN-1:0]  alu_regb;
  logic [7:0]       alu_imm;
  logic [TAG_W-1:0] alu_tag;
  logic             alu_stall;
  logic             alu_ready;
  logic             alu_done;
  logic [XLEN-1:0]  alu_result;
  logic [TAG_W-1:0] alu_done_tag;
  logic             mult_issue;
  logic [XLEN-1:0]  mult_opa;
  logic [XLEN-1:0]  mult_opb;
  logic [TAG_W-1:0] mult_tag;
  logic             mult_stall;
  logic             mult_ready;
  logic             mult_done;
  logic [XLEN-1:0]  mult_result;
  logic [TAG_W-1:0] mult_done_tag;
  logic             br_issue;
  br_func_t         br_func;
  logic [XLEN-1:0]  br_opa;
  logic             br_taken;

  logic [31:0]      lfsr_state;
  logic [TAG_W-1:0] next_tag;
  logic             check_latency;
  int               cycle = 0;
  // multiplies accepted but not yet written back, oldest first
  logic [XLEN-1:0]  exp_product [$];
  logic [TAG_W-1:0] exp_tag [$];
  int               issue_cycle [$];

  tb_clock_gen clock_gen (
    .clock (clock)
  );

  fu_bank fu_bank_inst (.*);

  always @(posedge clock) cycle <= cycle + 1;

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[XLEN-2:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // expected alu result, b already muxed
  function automatic logic [XLEN-1:0] ref_alu(input alu_func_t f, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    case (f)
      alu_addq:   r = a + b;
      alu_subq:   r = a - b;
      alu_and:    r = a & b;
      alu_bic:    r = a & ~b;
      alu_bis:    r = a | b;
      alu_ornot:  r = a | ~b;
      alu_xor:    r = a ^ b;
      alu_eqv:    r = ~(a ^ b);
      alu_srl:    r = a >> b[5:0];
      alu_sll:    r = a << b[5:0];
      alu_sra:    r = $signed(a) >>> b[5:0];
      alu_cmpult: r = {{(XLEN-1){1'b0}}, a < b};
      alu_cmpeq:  r = {{(XLEN-1){1'b0}}, a == b};
      alu_cmpule: r = {{(XLEN-1){1'b0}}, a <= b};
      alu_cmplt:  r = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      alu_cmple:  r = {{(XLEN-1){1'b0}}, $signed(a) <= $signed(b)};
      default:    r = '0;
    endcase
    return r;
  endfunction

  // low word of the full product
  function automatic logic [XLEN-1:0] ref_mult(input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] full;
    full = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    return full[XLEN-1:0];
  endfunction

  // branch condition, issue not included
  function automatic logic ref_branch(input br_func_t f, input logic [XLEN-1:0] a);
    logic c;
    case (f)
      br_lbc:  c = !a[0];
      br_eq:   c = (a == '0);
      br_lt:   c = a[XLEN-1];
      br_le:   c = a[XLEN-1] || (a == '0);
      br_lbs:  c = a[0];
      br_ne:   c = (a != '0);
      br_ge:   c = !a[XLEN-1];
      default: c = !a[XLEN-1] && (a != '0);
    endcase
    return c;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first failure");
  endtask

  // inputs change 10 ns after the rising edge
  task automatic drive_point();
    @(posedge clock);
    #10;
  endtask

  task automatic check_alu(input logic [XLEN-1:0] exp, input logic [TAG_W-1:0] tag);
    assert (alu_done == 1'b1)
      else report_failure($sformatf("Mismatch alu_done: got %h expected 1", alu_done));
    assert (alu_result == exp)
      else report_failure($sformatf("Mismatch alu_result: got %h expected %h", alu_result, exp));
    assert (alu_done_tag == tag)
      else report_failure($sformatf("Mismatch alu_done_tag: got %h expected %h", alu_done_tag, tag));
  endtask

  // one alu item, writeback stalled for hold_cycles after it completes
  task automatic alu_op(input alu_func_t f, input opb_select_t sel, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input logic [7:0] imm, input int hold_cycles);
    logic [XLEN-1:0]  opb;
    logic [XLEN-1:0]  exp;
    logic [TAG_W-1:0] tag;
    int               t;
    opb = (sel == opb_is_imm) ? {{(XLEN-8){1'b0}}, imm} : b;
    exp = ref_alu(f, a, opb);
    tag = next_tag;
    next_tag = next_tag + 1'b1;
    drive_point();
    alu_issue = 1'b1;
    alu_func = f;
    alu_opb_select = sel;
    alu_opa = a;
    alu_regb = b;
    alu_imm = imm;
    alu_tag = tag;
    alu_stall = (hold_cycles > 0);
    @(negedge clock);
    t = 0;
    while (!alu_ready) begin
      t++;
      if (t > TIMEOUT)
        report_failure("timeout waiting for alu_ready");
      @(negedge clock);
    end
    drive_point();
    alu_issue = 1'b0;
    // held result must not move, and no new item fits
    repeat (hold_cycles) begin
      @(negedge clock);
      check_alu(exp, tag);
      assert (alu_ready == 1'b0)
        else report_failure($sformatf("Mismatch alu_ready: got %h expected 0", alu_ready));
      drive_point();
    end
    alu_stall = 1'b0;
    @(negedge clock);
    check_alu(exp, tag);
  endtask

  task automatic load_mult();
    mult_issue = 1'b1;
    mult_opa = rand_bits(XLEN);
    mult_opb = rand_bits(XLEN);
    mult_tag = next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  // issue held high, operands change only once accepted
  task automatic mult_stream(input int count, input logic random_stall);
    int   sent;
    int   t;
    logic accepted;
    sent = 0;
    t = 0;
    drive_point();
    load_mult();
    while (sent < count) begin
      @(negedge clock);
      accepted = mult_ready;
      drive_point();
      if (random_stall)
        mult_stall = 1'(rand_bits(1));
      if (accepted) begin
        sent++;
        t = 0;
        if (sent < count)
          load_mult();
        else
          mult_issue = 1'b0;
      end else begin
        t++;
        if (t > TIMEOUT)
          report_failure("timeout waiting for mult_ready");
      end
    end
    mult_stall = 1'b0;
    t = 0;
    while (exp_product.size() != 0) begin
      t++;
      if (t > TIMEOUT)
        report_failure("timeout waiting for outstanding multiplies to complete");
      @(posedge clock);
    end
  endtask

  task automatic check_mult_result();
    logic [XLEN-1:0]  exp_p;
    logic [TAG_W-1:0] exp_t;
    int               c;
    assert (exp_product.size() != 0)
      else report_failure("mult_done is high with no multiply outstanding");
    exp_p = exp_product.pop_front();
    exp_t = exp_tag.pop_front();
    c = issue_cycle.pop_front();
    assert (mult_result == exp_p)
      else report_failure($sformatf("Mismatch mult_result: got %h expected %h", mult_result, exp_p));
    assert (mult_done_tag == exp_t)
      else report_failure($sformatf("Mismatch mult_done_tag: got %h expected %h",
                                    mult_done_tag, exp_t));
    if (check_latency)
      assert (cycle - c == `FU_MULT_STAGES)
        else report_failure($sformatf("multiply with tag %h took %0d cycles instead of %0d",
                                      exp_t, cycle - c, `FU_MULT_STAGES));
  endtask

  // scoreboard, sampled mid-cycle where everything is settled
  always @(negedge clock) begin
    if (!reset) begin
      // issue and ready now means accepted at the next edge
      if (mult_issue && mult_ready) begin
        exp_product.push_back(ref_mult(mult_opa, mult_opb));
        exp_tag.push_back(mult_tag);
        issue_cycle.push_back(cycle);
      end
      // done without stall means written back at the next edge
      if (mult_done && !mult_stall)
        check_mult_result();
    end
  end

  initial begin
    int              f;
    int              k;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [7:0]      imm;
    opb_select_t     sel;
    logic            issue_bit;
    logic            exp_taken;
    reset = 1'b1;
    alu_issue = 1'b0;
    alu_func = alu_addq;
    alu_opb_select = opb_is_regb;
    alu_opa = '0;
    alu_regb = '0;
    alu_imm = '0;
    alu_tag = '0;
    alu_stall = 1'b0;
    mult_issue = 1'b0;
    mult_opa = '0;
    mult_opb = '0;
    mult_tag = '0;
    mult_stall = 1'b0;
    br_issue = 1'b0;
    br_func = br_lbc;
    br_opa = '0;
    lfsr_state = 32'hcda6;
    next_tag = '0;
    check_latency = 1'b0;
    repeat (5) @(posedge clock);
    #10;
    reset = 1'b0;

    // idle state straight after reset
    @(negedge clock);
    assert (alu_done == 1'b0)
      else report_failure($sformatf("Mismatch alu_done: got %h expected 0", alu_done));
    assert (mult_done == 1'b0)
      else report_failure($sformatf("Mismatch mult_done: got %h expected 0", mult_done));
    assert (alu_ready == 1'b1)
      else report_failure($sformatf("Mismatch alu_ready: got %h expected 1", alu_ready));
    assert (mult_ready == 1'b1)
      else report_failure($sformatf("Mismatch mult_ready: got %h expected 1", mult_ready));

    // every opcode, random and corner operands
    for (f = 0; f < 16; f++) begin
      for (k = 0; k < 8; k++) begin
        a = rand_bits(XLEN);
        b = rand_bits(XLEN);
        imm = 8'(rand_bits(8));
        sel = opb_is_regb;
        case (k)
          1: sel = opb_is_imm;
          // shift by zero
          2: begin
            a[XLEN-1] = 1'b1;
            b = '0;
          end
          // shift by 63 from the literal
          3: begin
            a[XLEN-1] = 1'b1;
            imm = 8'd63;
            sel = opb_is_imm;
          end
          // signs differ both ways
          4: begin
            a[XLEN-1] = 1'b1;
            b[XLEN-1] = 1'b0;
          end
          5: begin
            a[XLEN-1] = 1'b0;
            b[XLEN-1] = 1'b1;
          end
          6: b = a;
          // upper bits of b must not affect the shift amount
          7: b[5:0] = 6'd63;
          default: ;
        endcase
        alu_op(alu_func_t'(f[3:0]), sel, a, b, imm, 0);
      end
    end

    // held results under writeback stall
    for (k = 0; k < 8; k++) begin
      alu_op(alu_func_t'(rand_bits(4)), opb_is_regb, rand_bits(XLEN), rand_bits(XLEN), 8'd0,
             1 + int'(rand_bits(2)));
    end

    // back to back, fixed latency
    check_latency = 1'b1;
    mult_stream(12, 1'b0);
    check_latency = 1'b0;
    // random writeback stall
    mult_stream(40, 1'b1);

    // every condition, operands zero, one, -1, negative, positive, random
    for (f = 0; f < 8; f++) begin
      for (k = 0; k < 12; k++) begin
        a = rand_bits(XLEN);
        case (k % 6)
          0: a = '0;
          1: a = 1;
          2: a = '1;
          3: a[XLEN-1] = 1'b1;
          4: a[XLEN-1] = 1'b0;
          default: ;
        endcase
        issue_bit = (k < 6);
        drive_point();
        br_issue = issue_bit;
        br_func = br_func_t'(f[2:0]);
        br_opa = a;
        @(negedge clock);
        exp_taken = issue_bit && ref_branch(br_func_t'(f[2:0]), a);
        assert (br_taken == exp_taken)
          else report_failure($sformatf("Mismatch br_taken: got %h expected %h", br_taken,
                                        exp_taken));
      end
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
fu_pkg.sv
alu.sv
mult_stage.sv
mult.sv
brcond.sv
fu_bank.sv
tb_clock_gen.sv
fu_bank_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fu_bank_tb
RTL_TOP   ?= fu_bank
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
